//--- hdl/rvSlice_consts.svh
//~~~~~~~~~~~~~~~~~~~~
// Widths, opcodes and function codes of the integer slice
// Included by the package, the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~
`ifndef RVSLICE_CONSTS_SVH
`define RVSLICE_CONSTS_SVH

// Data path and register file sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Accepted major opcodes
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LUI      7'b0110111

// funct3 codes shared by R-type and I-type
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 bit 5 set means SUB instead of ADD
`define F7B5_SUB    1'b1

// ADDI x0, x0, 0
`define NOP_INSTR   32'h0000_0013

`endif

//--- hdl/rvSlice_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Instruction field layouts and ALU operation type
// Imported by the stages that decode or execute
//~~~~~~~~~~~~~~~~~~~~
`include "rvSlice_consts.svh"

package rvSlicePkg;

    // Register-register format
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rTypeFieldsT;

    // Register-immediate format
    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iTypeFieldsT;

    // Upper-immediate format
    typedef struct packed {
        logic [19:0]            imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } uTypeFieldsT;

    // One fetched word seen through each format
    typedef union packed {
        rTypeFieldsT      r;
        iTypeFieldsT      i;
        uTypeFieldsT      u;
        logic [`XLEN-1:0] raw;
    } instrWordU;

    // Nine operations need a fourth bit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } aluOpT;

endpackage

//--- hdl/rvDecode.sv
//~~~~~~~~~~~~~~~~~~~~
// Decode stage of the slice: register file, immediates, ALU control
// Registers a decoded bundle for the execute stage every cycle
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvDecode import rvSlicePkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid_i,
    input  logic [`XLEN-1:0]       instr_i,
    input  logic                   wbValid_i,
    input  logic [`REG_ADDR_W-1:0] wbRd_i,
    input  logic [`XLEN-1:0]       wbData_i,
    output logic                   decValid_o,
    output logic [`REG_ADDR_W-1:0] decRd_o,
    output logic [`REG_ADDR_W-1:0] decRs1_o,
    output logic [`REG_ADDR_W-1:0] decRs2_o,
    output logic [`XLEN-1:0]       decOpA_o,
    output logic [`XLEN-1:0]       decOpB_o,
    output logic [`XLEN-1:0]       decImm_o,
    output logic                   decUseImm_o,
    output aluOpT                  decAluOp_o,
    output logic                   decWrites_o
);

    instrWordU        instrW;
    logic [`XLEN-1:0] regFile [`NUM_REGS];
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] imm;
    logic             useImm;
    logic             isSupported;
    aluOpT            aluOp;

    assign instrW = instr_i;

    // Write-through so a same-cycle writeback is seen by the read
    assign rs1Data = (wbValid_i && wbRd_i == instrW.r.rs1) ? wbData_i : regFile[instrW.r.rs1];
    assign rs2Data = (wbValid_i && wbRd_i == instrW.r.rs2) ? wbData_i : regFile[instrW.r.rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid_i) begin
            regFile[wbRd_i] <= wbData_i;
        end
    end

    always_comb begin
        aluOp       = ALU_ADD;
        useImm      = 1'b0;
        isSupported = 1'b0;
        imm         = {{(`XLEN-12){instrW.i.imm[11]}}, instrW.i.imm};
        case (instrW.r.opcode)
            `OP_RTYPE: begin
                isSupported = 1'b1;
                case (instrW.r.funct3)
                    `F3_ADD: aluOp = (instrW.r.funct7[5] == `F7B5_SUB) ? ALU_SUB : ALU_ADD;
                    `F3_SLL: aluOp = ALU_SLL;
                    `F3_SLT: aluOp = ALU_SLT;
                    `F3_XOR: aluOp = ALU_XOR;
                    `F3_OR:  aluOp = ALU_OR;
                    `F3_AND: aluOp = ALU_AND;
                    `F3_SRL: begin
                        aluOp = ALU_SRL;
                        // SRA shares funct3, not supported
                        isSupported = (instrW.r.funct7[5] != `F7B5_SUB);
                    end
                    default: isSupported = 1'b0;
                endcase
            end
            `OP_ITYPE: begin
                isSupported = 1'b1;
                useImm      = 1'b1;
                case (instrW.i.funct3)
                    `F3_ADD: aluOp = ALU_ADD;
                    `F3_SLT: aluOp = ALU_SLT;
                    `F3_XOR: aluOp = ALU_XOR;
                    `F3_OR:  aluOp = ALU_OR;
                    `F3_AND: aluOp = ALU_AND;
                    default: isSupported = 1'b0;
                endcase
            end
            `OP_LUI: begin
                isSupported = 1'b1;
                useImm      = 1'b1;
                aluOp       = ALU_PASSB;
                imm         = {instrW.u.imm, {(`XLEN-20){1'b0}}};
            end
            default: isSupported = 1'b0;
        endcase
    end

    // Slot control, x0 destinations never write
    always_ff @(posedge clk) begin
        if (reset) begin
            decValid_o  <= 1'b0;
            decWrites_o <= 1'b0;
        end else begin
            decValid_o  <= instrValid_i && isSupported;
            decWrites_o <= instrValid_i && isSupported && (instrW.r.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        decRd_o     <= instrW.r.rd;
        decRs1_o    <= instrW.r.rs1;
        decRs2_o    <= instrW.r.rs2;
        decOpA_o    <= rs1Data;
        decOpB_o    <= rs2Data;
        decImm_o    <= imm;
        decUseImm_o <= useImm;
        decAluOp_o  <= aluOp;
    end

endmodule

//--- hdl/rvExecute.sv
//~~~~~~~~~~~~~~~~~~~~
// Execute stage: operand forwarding and the ALU
// Registers the result bundle for the result stage
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvExecute import rvSlicePkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   decValid_i,
    input  logic [`REG_ADDR_W-1:0] decRd_i,
    input  logic [`REG_ADDR_W-1:0] decRs1_i,
    input  logic [`REG_ADDR_W-1:0] decRs2_i,
    input  logic [`XLEN-1:0]       decOpA_i,
    input  logic [`XLEN-1:0]       decOpB_i,
    input  logic [`XLEN-1:0]       decImm_i,
    input  logic                   decUseImm_i,
    input  aluOpT                  decAluOp_i,
    input  logic                   decWrites_i,
    input  logic                   wbValid_i,
    input  logic [`REG_ADDR_W-1:0] wbRd_i,
    input  logic [`XLEN-1:0]       wbData_i,
    output logic                   exValid_o,
    output logic [`REG_ADDR_W-1:0] exRd_o,
    output logic [`XLEN-1:0]       exResult_o,
    output logic                   exWrites_o
);

    logic             exLive;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] regB;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic [4:0]       shamt;

    // Own result register holds the instruction just ahead
    assign exLive = exValid_o && exWrites_o;

    // Newest producer wins, then writeback, then the decoded read
    always_comb begin
        if (exLive && exRd_o == decRs1_i) begin
            srcA = exResult_o;
        end else if (wbValid_i && wbRd_i == decRs1_i) begin
            srcA = wbData_i;
        end else begin
            srcA = decOpA_i;
        end

        if (exLive && exRd_o == decRs2_i) begin
            regB = exResult_o;
        end else if (wbValid_i && wbRd_i == decRs2_i) begin
            regB = wbData_i;
        end else begin
            regB = decOpB_i;
        end
    end

    assign srcB  = decUseImm_i ? decImm_i : regB;
    assign shamt = srcB[4:0];

    always_comb begin
        case (decAluOp_i)
            ALU_ADD:   aluResult = srcA + srcB;
            ALU_SUB:   aluResult = srcA - srcB;
            ALU_AND:   aluResult = srcA & srcB;
            ALU_OR:    aluResult = srcA | srcB;
            ALU_XOR:   aluResult = srcA ^ srcB;
            ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLL:   aluResult = srcA << shamt;
            ALU_SRL:   aluResult = srcA >> shamt;
            ALU_PASSB: aluResult = srcB;
            default:   aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid_o  <= 1'b0;
            exWrites_o <= 1'b0;
        end else begin
            exValid_o  <= decValid_i;
            exWrites_o <= decWrites_i;
        end
    end

    always_ff @(posedge clk) begin
        exRd_o     <= decRd_i;
        exResult_o <= aluResult;
    end

endmodule

//--- hdl/rvResult.sv
//~~~~~~~~~~~~~~~~~~~~
// Result stage holding the writeback register
// Drives the register file write and the forwarding sources
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvResult (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exValid_i,
    input  logic [`REG_ADDR_W-1:0] exRd_i,
    input  logic [`XLEN-1:0]       exResult_i,
    input  logic                   exWrites_i,
    output logic                   wbValid_o,
    output logic [`REG_ADDR_W-1:0] wbRd_o,
    output logic [`XLEN-1:0]       wbData_o
);

    logic wbEnable;

    // Only slots that really write a register count downstream
    assign wbEnable = exValid_i && exWrites_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid_o <= 1'b0;
        end else begin
            wbValid_o <= wbEnable;
        end
    end

    // Payload keeps the last value on bubbles
    always_ff @(posedge clk) begin
        if (wbEnable) begin
            wbRd_o   <= exRd_i;
            wbData_o <= exResult_i;
        end
    end

endmodule

//--- hdl/rvSliceTop.sv
//~~~~~~~~~~~~~~~~~~~~
// Top of the three-stage integer slice
// Instructions in, register writes out three cycles later
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvSliceTop import rvSlicePkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid_i,
    input  logic [`XLEN-1:0]       instr_i,
    output logic                   wbValid_o,
    output logic [`REG_ADDR_W-1:0] wbRd_o,
    output logic [`XLEN-1:0]       wbData_o
);

    // Decode to execute
    logic                   decValid;
    logic [`REG_ADDR_W-1:0] decRd;
    logic [`REG_ADDR_W-1:0] decRs1;
    logic [`REG_ADDR_W-1:0] decRs2;
    logic [`XLEN-1:0]       decOpA;
    logic [`XLEN-1:0]       decOpB;
    logic [`XLEN-1:0]       decImm;
    logic                   decUseImm;
    aluOpT                  decAluOp;
    logic                   decWrites;

    // Execute to result
    logic                   exValid;
    logic [`REG_ADDR_W-1:0] exRd;
    logic [`XLEN-1:0]       exResult;
    logic                   exWrites;

    rvDecode decode_i (
        .clk(clk), .reset(reset),
        .instrValid_i(instrValid_i), .instr_i(instr_i),
        .wbValid_i(wbValid_o), .wbRd_i(wbRd_o), .wbData_i(wbData_o),
        .decValid_o(decValid), .decRd_o(decRd),
        .decRs1_o(decRs1), .decRs2_o(decRs2),
        .decOpA_o(decOpA), .decOpB_o(decOpB), .decImm_o(decImm),
        .decUseImm_o(decUseImm), .decAluOp_o(decAluOp), .decWrites_o(decWrites)
    );

    rvExecute execute_i (
        .clk(clk), .reset(reset),
        .decValid_i(decValid), .decRd_i(decRd),
        .decRs1_i(decRs1), .decRs2_i(decRs2),
        .decOpA_i(decOpA), .decOpB_i(decOpB), .decImm_i(decImm),
        .decUseImm_i(decUseImm), .decAluOp_i(decAluOp), .decWrites_i(decWrites),
        .wbValid_i(wbValid_o), .wbRd_i(wbRd_o), .wbData_i(wbData_o),
        .exValid_o(exValid), .exRd_o(exRd), .exResult_o(exResult), .exWrites_o(exWrites)
    );

    rvResult result_i (
        .clk(clk), .reset(reset),
        .exValid_i(exValid), .exRd_i(exRd), .exResult_i(exResult), .exWrites_i(exWrites),
        .wbValid_o(wbValid_o), .wbRd_o(wbRd_o), .wbData_o(wbData_o)
    );

endmodule

//--- verif/rvSlice_chk.sv
//~~~~~~~~~~~~~~~~~~~~
// Writeback protocol assertions bound to the slice top
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvSliceChk (
    input logic                   clk,
    input logic                   reset,
    input logic                   instrValid_i,
    input logic                   wbValid_i,
    input logic [`REG_ADDR_W-1:0] wbRd_i
);

    // Failed assertions so far
    int failCount = 0;

    // Nothing leaves the pipe while it is held in reset
    resetQuiet: assert property (@(posedge clk) reset |=> !wbValid_i)
        else begin
            failCount++;
            $error("writeback valid following a reset cycle");
        end

    // x0 writes are dropped in decode
    noWriteToX0: assert property (@(posedge clk) disable iff (reset)
        wbValid_i |-> wbRd_i != '0)
        else begin
            failCount++;
            $error("writeback to register x0");
        end

    // One cycle in each of the three stages
    fixedLatency: assert property (@(posedge clk) disable iff (reset)
        wbValid_i |-> $past(instrValid_i, 3))
        else begin
            failCount++;
            $error("writeback without a valid instruction three cycles earlier");
        end

endmodule

bind rvSliceTop rvSliceChk chk_i (
    .clk(clk),
    .reset(reset),
    .instrValid_i(instrValid_i),
    .wbValid_i(wbValid_o),
    .wbRd_i(wbRd_o)
);

//--- verif/rvSliceTb.sv
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the integer slice fed from the pattern file
// Inserts random bubbles and checks writes in order at fixed latency
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "rvSlice_consts.svh"

module rvSliceTb;

    localparam int MaxEntries    = 64;
    localparam int WordsPerEntry = 4;
    localparam int Latency       = 3;
    localparam logic [31:0] EndMarker = 32'hffff_ffff;

    logic                   clk;
    logic                   reset;
    logic                   instrValid;
    logic [`XLEN-1:0]       instr;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic [`XLEN-1:0]       wbData;

    // Each entry holds instruction, rd, value and test id
    logic [31:0] patMem [MaxEntries*WordsPerEntry];
    int          patCount;
    int          timeoutLimit;
    logic        limitReady = 1'b0;
    int          cycleCount = 0;
    logic [31:0] lfsrState;
    int          mismatchCount = 0;
    int          orderErrorCount = 0;
    int          setupErrorCount = 0;

    // Expected writes in program order
    logic [`REG_ADDR_W-1:0] expRdQ[$];
    logic [`XLEN-1:0]       expDataQ[$];
    int                     expCycleQ[$];
    int                     expTestQ[$];

    rvSliceTop dut_i (
        .clk(clk), .reset(reset),
        .instrValid_i(instrValid), .instr_i(instr),
        .wbValid_o(wbValid), .wbRd_o(wbRd), .wbData_o(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Taps of x^32 + x^22 + x^2 + x + 1
    // New bit enters at bit 0
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic string testName(input int testId);
        case (testId)
            1:       return "arith_logic";
            2:       return "lui";
            3:       return "forwarding";
            4:       return "x0_and_unsupported";
            default: return "unknown";
        endcase
    endfunction

    task automatic loadPatterns();
        logic found;
        $readmemh("verif/rvSlice_patterns.hex", patMem);
        found    = 1'b0;
        patCount = 0;
        for (int k = 0; k < MaxEntries && !found; k++) begin
            if (patMem[k*WordsPerEntry] === EndMarker) begin
                found = 1'b1;
            end else begin
                patCount++;
            end
        end
        assert (found && patCount > 0) else begin
            $display("ERROR: pattern file is empty or has no end marker");
            setupErrorCount++;
        end
    endtask

    task automatic driveBubble();
        instrValid = 1'b0;
        instr      = `NOP_INSTR;
    endtask

    task automatic driveEntry(input int idx);
        int base;
        base       = idx * WordsPerEntry;
        instr      = patMem[base];
        instrValid = 1'b1;
        // Expected rd of zero means the slot writes nothing
        if (patMem[base+1][`REG_ADDR_W-1:0] != '0) begin
            expRdQ.push_back(patMem[base+1][`REG_ADDR_W-1:0]);
            expDataQ.push_back(patMem[base+2]);
            expCycleQ.push_back(cycleCount + Latency);
            expTestQ.push_back(int'(patMem[base+3]));
        end
    endtask

    task automatic checkWrite();
        logic [`REG_ADDR_W-1:0] eRd;
        logic [`XLEN-1:0]       eData;
        int                     eCycle;
        int                     eTest;
        assert (expRdQ.size() != 0) else begin
            $display("ERROR: write of 0x%08h to x%0d when no write was expected", wbData, wbRd);
            orderErrorCount++;
        end
        if (expRdQ.size() != 0) begin
            eRd    = expRdQ.pop_front();
            eData  = expDataQ.pop_front();
            eCycle = expCycleQ.pop_front();
            eTest  = expTestQ.pop_front();
            assert (wbRd == eRd) else begin
                $display("MISMATCH %s: rd expected x%0d actual x%0d", testName(eTest), eRd, wbRd);
                mismatchCount++;
            end
            assert (wbData == eData) else begin
                $display("MISMATCH %s: x%0d expected 0x%08h actual 0x%08h",
                         testName(eTest), eRd, eData, wbData);
                mismatchCount++;
            end
            assert (cycleCount == eCycle) else begin
                $display("ERROR: %s write to x%0d arrived in cycle %0d instead of cycle %0d",
                         testName(eTest), eRd, cycleCount, eCycle);
                orderErrorCount++;
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && wbValid) begin
            checkWrite();
        end
    end

    initial begin
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = `NOP_INSTR;
        lfsrState  = 32'h23a7;
        loadPatterns();
        // At most one bubble per entry plus reset and drain
        timeoutLimit = 2 * patCount + 20;
        limitReady   = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int idx = 0; idx < patCount; idx++) begin
            lfsrState = stepLfsr(lfsrState);
            if (lfsrState[0]) begin
                driveBubble();
                @(posedge clk);
                #2;
            end
            driveEntry(idx);
            @(posedge clk);
            #2;
        end
        driveBubble();
        while (expRdQ.size() != 0) begin
            @(posedge clk);
        end
        // Room for any stray write behind the last one
        repeat (Latency + 1) @(posedge clk);
        $display("Errors: %0d mismatches, %0d ordering, %0d setup, %0d assertion",
                 mismatchCount, orderErrorCount, setupErrorCount, dut_i.chk_i.failCount);
        if (mismatchCount == 0 && orderErrorCount == 0 && setupErrorCount == 0 &&
            dut_i.chk_i.failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (limitReady);
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
        end
        $display("ERROR: run did not finish within %0d cycles, %0d writes still pending",
                 timeoutLimit, expRdQ.size());
        $display("Errors: %0d mismatches, %0d ordering, %0d setup, %0d assertion",
                 mismatchCount, orderErrorCount, setupErrorCount, dut_i.chk_i.failCount);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verif/rvSlice_patterns.hex
// instr    rd  expected  test id (1 arith_logic, 2 lui, 3 forwarding, 4 x0_and_unsupported)
// rd 00 means no write is expected; instr ffffffff ends the list
00500093 01 00000005 1
ffd00113 02 fffffffd 1
7f000193 03 000007f0 1
00208233 04 00000002 1
402082b3 05 00000008 1
0021f333 06 000007f0 1
0030e3b3 07 000007f5 1
00114433 08 fffffff8 1
001124b3 09 00000001 1
0020a533 0a 00000000 1
004095b3 0b 00000014 1
00415633 0c 3fffffff 1
ffe12693 0d 00000001 1
0f01f713 0e 000000f0 1
ff00e793 0f fffffff5 1
0ff0c813 10 000000fa 1
123458b7 11 12345000 2
fffff937 12 fffff000 2
67888993 13 12345678 3
01398a33 14 2468acf0 3
413a0ab3 15 12345678 3
014acb33 16 365cfa88 3
001b0b13 16 365cfa89 3
013b7bb3 17 12145208 3
00508013 00 00000000 4
00100d33 1a 00000005 4
0000ac03 00 00000000 4
4040dcb3 00 00000000 4
00006db3 1b 00000000 4
00000013 00 00000000 4
ffffffff 00 00000000 0

//--- rvSlice.f
+incdir+hdl
hdl/rvSlice_pkg.sv
hdl/rvDecode.sv
hdl/rvExecute.sv
hdl/rvResult.sv
hdl/rvSliceTop.sv
verif/rvSlice_chk.sv
verif/rvSliceTb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rvSlice testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -sv -f rvSlice.f --top-module rvSliceTb

status=0
./obj_dir/VrvSliceTb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qx "Result: FAILED" "$LOG" || [ "$status" -ne 0 ]; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

if ! grep -qx "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi

echo "Simulation passed"
